/* logic/axi_mem_consts.svh */
`ifndef AXI_MEM_CONSTS_SVH
`define AXI_MEM_CONSTS_SVH

// Bus widths of the AXI port.
`define AXI_ID_W     4
`define AXI_ADDR_W   64
`define AXI_DATA_W   64
`define AXI_STRB_W   8

// Attribute field widths.
`define AXI_LEN_W    8
`define AXI_SIZE_W   3
`define AXI_BURST_W  2

// The memory holds 1024 words of eight bytes.
`define MEM_AW       10
`define MEM_DEPTH    (1 << `MEM_AW)

// Only single eight-byte incrementing beats are served.
`define AXI_SIZE_WORD   3'd3
`define AXI_BURST_INCR  2'd1

`endif

/* logic/axi_mem_pkg.sv */
`include "axi_mem_consts.svh"

package axi_mem_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    typedef logic [`AXI_ID_W-1:0]   id_t;
    typedef logic [`AXI_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_DATA_W-1:0] data_t;
    typedef logic [`AXI_STRB_W-1:0] strb_t;
    typedef logic [`MEM_AW-1:0]     widx_t;

    // Attribute errors win over a bad address.
    function automatic resp_t check_req(
        input addr_t                   addr,
        input logic [`AXI_LEN_W-1:0]   len,
        input logic [`AXI_SIZE_W-1:0]  size,
        input logic [`AXI_BURST_W-1:0] burst
    );
        if (len != '0 || size != `AXI_SIZE_WORD || burst != `AXI_BURST_INCR)
            return SLVERR;
        if (addr[`AXI_ADDR_W-1:`MEM_AW+3] != '0)
            return DECERR;
        return OKAY;
    endfunction

endpackage

/* logic/word_mem.sv */
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module word_mem #(
    parameter int AW = `MEM_AW
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                wr_en,
    input  axi_mem_pkg::widx_t  wr_idx,
    input  axi_mem_pkg::data_t  wr_data,
    input  axi_mem_pkg::strb_t  wr_strb,

    input  logic                rd_en,
    input  axi_mem_pkg::widx_t  rd_idx,
    output axi_mem_pkg::data_t  rd_data
);
    import axi_mem_pkg::*;

    localparam int DEPTH = 1 << AW;

    data_t mem [0:DEPTH-1];

    // ******************************************************************
    // Write port, one byte lane per strobe bit.
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < $bits(strb_t); i++) begin
                if (wr_strb[i])
                    mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
    end

    // ******************************************************************
    // Read port, registered.
    // ******************************************************************
    // The output register keeps its value between reads, so the read
    // slave can hold R data for as long as the master stalls.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

/* logic/axi_write_slave.sv */
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module axi_write_slave (
    input  logic                     clk,
    input  logic                     rst_n,

    // Write address channel.
    input  axi_mem_pkg::id_t         aw_id,
    input  axi_mem_pkg::addr_t       aw_addr,
    input  logic [`AXI_LEN_W-1:0]    aw_len,
    input  logic [`AXI_SIZE_W-1:0]   aw_size,
    input  logic [`AXI_BURST_W-1:0]  aw_burst,
    input  logic                     aw_valid,
    output logic                     aw_ready,

    // Write data channel.
    input  axi_mem_pkg::data_t       w_data,
    input  axi_mem_pkg::strb_t       w_strb,
    input  logic                     w_last,
    input  logic                     w_valid,
    output logic                     w_ready,

    // Write response channel.
    output axi_mem_pkg::id_t         b_id,
    output axi_mem_pkg::resp_t       b_resp,
    output logic                     b_valid,
    input  logic                     b_ready,

    // Memory write port.
    output logic                     mem_wr_en,
    output axi_mem_pkg::widx_t       mem_wr_idx,
    output axi_mem_pkg::data_t       mem_wr_data,
    output axi_mem_pkg::strb_t       mem_wr_strb
);
    import axi_mem_pkg::*;

    typedef enum logic {
        IDLE,
        RESP
    } state_t;

    state_t state;
    logic   accept;
    logic   wr_pend;
    resp_t  req_resp;

    // ******************************************************************
    // Joint AW/W acceptance.
    // ******************************************************************
    // Both channels are taken in the same cycle, and only when both
    // present a request, so address and data are never split.
    assign aw_ready = (state == IDLE) && aw_valid && w_valid;
    assign w_ready  = aw_ready;
    assign accept   = aw_ready;

    // A single beat must carry w_last; otherwise the burst is malformed.
    always_comb begin
        if (!w_last)
            req_resp = SLVERR;
        else
            req_resp = check_req(aw_addr, aw_len, aw_size, aw_burst);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (accept) state <= RESP;
                RESP: if (b_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // One-cycle write pulse in the first RESP cycle, good requests only.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= accept && (req_resp == OKAY);
        end
    end

    // ******************************************************************
    // Captured request.
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (accept) begin
            b_id        <= aw_id;
            b_resp      <= req_resp;
            mem_wr_idx  <= aw_addr[3 +: `MEM_AW];
            mem_wr_data <= w_data;
            mem_wr_strb <= w_strb;
        end
    end

    assign b_valid   = (state == RESP);
    assign mem_wr_en = wr_pend;

endmodule

/* logic/axi_read_slave.sv */
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module axi_read_slave (
    input  logic                     clk,
    input  logic                     rst_n,

    // Read address channel.
    input  axi_mem_pkg::id_t         ar_id,
    input  axi_mem_pkg::addr_t       ar_addr,
    input  logic [`AXI_LEN_W-1:0]    ar_len,
    input  logic [`AXI_SIZE_W-1:0]   ar_size,
    input  logic [`AXI_BURST_W-1:0]  ar_burst,
    input  logic                     ar_valid,
    output logic                     ar_ready,

    // Read data channel.
    output axi_mem_pkg::id_t         r_id,
    output axi_mem_pkg::data_t       r_data,
    output axi_mem_pkg::resp_t       r_resp,
    output logic                     r_last,
    output logic                     r_valid,
    input  logic                     r_ready,

    // Memory read port.
    output logic                     mem_rd_en,
    output axi_mem_pkg::widx_t       mem_rd_idx,
    input  axi_mem_pkg::data_t       mem_rd_data
);
    import axi_mem_pkg::*;

    typedef enum logic {
        IDLE,
        DATA
    } state_t;

    state_t state;
    logic   accept;
    resp_t  req_resp;

    // ******************************************************************
    // Request decode and memory read.
    // ******************************************************************
    assign ar_ready = (state == IDLE);
    assign accept   = ar_valid && ar_ready;
    assign req_resp = check_req(ar_addr, ar_len, ar_size, ar_burst);

    // The read is issued in the accept cycle so the word is ready with R.
    assign mem_rd_en  = accept && (req_resp == OKAY);
    assign mem_rd_idx = ar_addr[3 +: `MEM_AW];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (accept) state <= DATA;
                DATA: if (r_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            r_id   <= ar_id;
            r_resp <= req_resp;
        end
    end

    // ******************************************************************
    // R channel.
    // ******************************************************************
    // The memory output register is not reloaded until the next accept,
    // so the data stays put while the master stalls.
    assign r_valid = (state == DATA);
    assign r_last  = r_valid;
    assign r_data  = (r_resp == OKAY) ? mem_rd_data : '0;

endmodule

/* logic/axi_mem_top.sv */
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module axi_mem_top (
    input  logic                     clk,
    input  logic                     rst_n,

    input  axi_mem_pkg::id_t         aw_id,
    input  axi_mem_pkg::addr_t       aw_addr,
    input  logic [`AXI_LEN_W-1:0]    aw_len,
    input  logic [`AXI_SIZE_W-1:0]   aw_size,
    input  logic [`AXI_BURST_W-1:0]  aw_burst,
    input  logic                     aw_valid,
    output logic                     aw_ready,

    input  axi_mem_pkg::data_t       w_data,
    input  axi_mem_pkg::strb_t       w_strb,
    input  logic                     w_last,
    input  logic                     w_valid,
    output logic                     w_ready,

    output axi_mem_pkg::id_t         b_id,
    output axi_mem_pkg::resp_t       b_resp,
    output logic                     b_valid,
    input  logic                     b_ready,

    input  axi_mem_pkg::id_t         ar_id,
    input  axi_mem_pkg::addr_t       ar_addr,
    input  logic [`AXI_LEN_W-1:0]    ar_len,
    input  logic [`AXI_SIZE_W-1:0]   ar_size,
    input  logic [`AXI_BURST_W-1:0]  ar_burst,
    input  logic                     ar_valid,
    output logic                     ar_ready,

    output axi_mem_pkg::id_t         r_id,
    output axi_mem_pkg::data_t       r_data,
    output axi_mem_pkg::resp_t       r_resp,
    output logic                     r_last,
    output logic                     r_valid,
    input  logic                     r_ready
);
    import axi_mem_pkg::*;

    logic  mem_wr_en;
    widx_t mem_wr_idx;
    data_t mem_wr_data;
    strb_t mem_wr_strb;

    logic  mem_rd_en;
    widx_t mem_rd_idx;
    data_t mem_rd_data;

    axi_write_slave u_write_slave (
        .clk         (clk),
        .rst_n       (rst_n),
        .aw_id       (aw_id),
        .aw_addr     (aw_addr),
        .aw_len      (aw_len),
        .aw_size     (aw_size),
        .aw_burst    (aw_burst),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w_data      (w_data),
        .w_strb      (w_strb),
        .w_last      (w_last),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .b_id        (b_id),
        .b_resp      (b_resp),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_idx  (mem_wr_idx),
        .mem_wr_data (mem_wr_data),
        .mem_wr_strb (mem_wr_strb)
    );

    word_mem #(
        .AW (`MEM_AW)
    ) u_word_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (mem_wr_en),
        .wr_idx  (mem_wr_idx),
        .wr_data (mem_wr_data),
        .wr_strb (mem_wr_strb),
        .rd_en   (mem_rd_en),
        .rd_idx  (mem_rd_idx),
        .rd_data (mem_rd_data)
    );

    axi_read_slave u_read_slave (
        .clk         (clk),
        .rst_n       (rst_n),
        .ar_id       (ar_id),
        .ar_addr     (ar_addr),
        .ar_len      (ar_len),
        .ar_size     (ar_size),
        .ar_burst    (ar_burst),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .r_id        (r_id),
        .r_data      (r_data),
        .r_resp      (r_resp),
        .r_last      (r_last),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_idx  (mem_rd_idx),
        .mem_rd_data (mem_rd_data)
    );

endmodule

/* bench/axi_mem_asserts.sv */
`timescale 1ns/1ps

module axi_mem_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               aw_ready,
    input logic               w_ready,
    input logic               b_valid,
    input logic               b_ready,
    input axi_mem_pkg::resp_t b_resp,
    input logic               r_valid,
    input logic               r_ready,
    input logic               mem_wr_en
);
    import axi_mem_pkg::*;

    // A response stays offered until the master takes it.
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid && !b_ready |=> b_valid)
        else $error("b_valid dropped before b_ready");

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid)
        else $error("r_valid dropped before r_ready");

    // Address and data are taken together, and B follows one cycle later.
    aw_with_w: assert property (@(posedge clk) disable iff (!rst_n)
        aw_ready |=> $past(w_ready) && b_valid)
        else $error("write accepted without w_ready or without a response next cycle");

    // The write pulse falls in the first RESP cycle, while b_resp is held.
    wr_only_okay: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wr_en |-> b_resp == OKAY)
        else $error("memory write issued for a rejected request");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !b_valid && !r_valid)
        else $error("response valid in the first cycle after reset");

endmodule

bind axi_mem_top axi_mem_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .aw_ready  (aw_ready),
    .w_ready   (w_ready),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .b_resp    (b_resp),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .mem_wr_en (mem_wr_en)
);

/* bench/axi_mem_tb.sv */
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module axi_mem_tb;
    import axi_mem_pkg::*;

    logic clk;
    logic rst_n;

    id_t                    aw_id;
    addr_t                  aw_addr;
    logic [`AXI_LEN_W-1:0]  aw_len;
    logic [`AXI_SIZE_W-1:0] aw_size;
    logic [`AXI_BURST_W-1:0] aw_burst;
    logic                   aw_valid;
    logic                   aw_ready;
    data_t                  w_data;
    strb_t                  w_strb;
    logic                   w_last;
    logic                   w_valid;
    logic                   w_ready;
    id_t                    b_id;
    resp_t                  b_resp;
    logic                   b_valid;
    logic                   b_ready;
    id_t                    ar_id;
    addr_t                  ar_addr;
    logic [`AXI_LEN_W-1:0]  ar_len;
    logic [`AXI_SIZE_W-1:0] ar_size;
    logic [`AXI_BURST_W-1:0] ar_burst;
    logic                   ar_valid;
    logic                   ar_ready;
    id_t                    r_id;
    data_t                  r_data;
    resp_t                  r_resp;
    logic                   r_last;
    logic                   r_valid;
    logic                   r_ready;

    // Reference copy of the memory; only OKAY writes change it.
    data_t model_mem [0:`MEM_DEPTH-1];
    bit    written [0:`MEM_DEPTH-1];
    widx_t written_q [$];

    int seed = 98383;
    int value_errors = 0;
    int protocol_errors = 0;
    int timeouts = 0;

    axi_mem_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ******************************************************************
    // Random helpers and the response model.
    // ******************************************************************
    function automatic logic [31:0] rnd32();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = rnd32();
        return int'(r % n);
    endfunction

    function automatic data_t rand_data();
        return {rnd32(), rnd32()};
    endfunction

    function automatic widx_t rand_idx();
        logic [31:0] r;
        r = rnd32();
        return r[`MEM_AW-1:0];
    endfunction

    function automatic widx_t pick_written();
        return written_q[rand_below(written_q.size())];
    endfunction

    function automatic addr_t in_addr(input widx_t idx);
        addr_t       a;
        logic [31:0] r;
        r = rnd32();
        a = '0;
        a[3 +: `MEM_AW] = idx;
        a[2:0] = r[2:0];
        return a;
    endfunction

    // Same word index, but with upper address bits set.
    function automatic addr_t far_addr(input widx_t idx);
        addr_t a;
        a = in_addr(idx);
        a[63:32] = rnd32();
        a[20] = 1'b1;
        return a;
    endfunction

    function automatic resp_t expected_resp(input addr_t addr, input logic [7:0] len,
                                            input logic [2:0] size, input logic [1:0] burst);
        if (len != 8'd0 || size != 3'd3 || burst != 2'd1)
            return SLVERR;
        if ((addr >> (`MEM_AW + 3)) != 64'd0)
            return DECERR;
        return OKAY;
    endfunction

    task automatic bad_attr(output logic [7:0] len, output logic [2:0] size,
                            output logic [1:0] burst);
        logic [31:0] r;
        r = rnd32();
        len = 8'd0;
        size = 3'd3;
        burst = 2'd1;
        case (rand_below(3))
            0: len = r[7:0] | 8'h01;
            1: size = (r[2:0] == 3'd3) ? 3'd2 : r[2:0];
            default: burst = (r[1:0] == 2'd1) ? 2'd2 : r[1:0];
        endcase
    endtask

    // ******************************************************************
    // Compare tasks and failure reporting.
    // ******************************************************************
    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (act !== exp) begin
            $display("Error %s: expected resp %0h, actual %0h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("Error %s: expected data %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_id(input string name, input id_t exp, input id_t act);
        if (act !== exp) begin
            $display("Error %s: expected id %0h, actual %0h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic report_failure(input string name, input string msg);
        $display("%s: %s", name, msg);
        protocol_errors++;
    endtask

    // Outputs are looked at on falling edges where they have long settled.
    task automatic wait_signal(input int sel, input string what, output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        while (!ok && n < 100) begin
            @(negedge clk);
            case (sel)
                0: ok = aw_ready && w_ready;
                1: ok = b_valid;
                2: ok = ar_ready;
                default: ok = r_valid;
            endcase
            n++;
        end
        if (!ok) begin
            $display("Timeout after 100 cycles waiting for %s", what);
            timeouts++;
        end
    endtask

    // ******************************************************************
    // Transactions.
    // ******************************************************************
    task automatic write_txn(input string name, input addr_t addr, input logic [7:0] len,
                             input logic [2:0] size, input logic [1:0] burst,
                             input data_t data, input strb_t strb, input int stall);
        logic [31:0] r;
        id_t         id;
        resp_t       exp;
        widx_t       idx;
        bit          ok;
        r = rnd32();
        id = r[3:0];
        idx = addr[3 +: `MEM_AW];
        exp = expected_resp(addr, len, size, burst);
        @(posedge clk);
        aw_id <= id;
        aw_addr <= addr;
        aw_len <= len;
        aw_size <= size;
        aw_burst <= burst;
        aw_valid <= 1'b1;
        w_data <= data;
        w_strb <= strb;
        w_last <= 1'b1;
        w_valid <= 1'b1;
        wait_signal(0, "write address and data ready", ok);
        @(posedge clk);
        aw_valid <= 1'b0;
        w_valid <= 1'b0;
        if (exp == OKAY) begin
            for (int b = 0; b < 8; b++) begin
                if (strb[b])
                    model_mem[idx][8*b +: 8] = data[8*b +: 8];
            end
            if (!written[idx] && strb == 8'hff) begin
                written[idx] = 1'b1;
                written_q.push_back(idx);
            end
        end
        wait_signal(1, "write response valid", ok);
        check_resp(name, exp, b_resp);
        check_id(name, id, b_id);
        // A second request is offered during the stall and must not be taken.
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            aw_valid <= 1'b1;
            w_valid <= 1'b1;
            @(negedge clk);
            if (!b_valid)
                report_failure(name, "write response dropped before b_ready");
            if (aw_ready || w_ready)
                report_failure(name, "write accepted while a response was pending");
            check_resp(name, exp, b_resp);
            check_id(name, id, b_id);
        end
        @(posedge clk);
        aw_valid <= 1'b0;
        w_valid <= 1'b0;
        b_ready <= 1'b1;
        @(posedge clk);
        b_ready <= 1'b0;
    endtask

    task automatic check_read(input string name, input id_t id, input resp_t exp,
                              input data_t exp_data);
        if (!r_valid || !r_last)
            report_failure(name, "read data not valid with last set");
        check_resp(name, exp, r_resp);
        check_id(name, id, r_id);
        check_data(name, exp_data, r_data);
    endtask

    task automatic read_txn(input string name, input addr_t addr, input logic [7:0] len,
                            input logic [2:0] size, input logic [1:0] burst, input int stall);
        logic [31:0] r;
        id_t         id;
        resp_t       exp;
        data_t       exp_data;
        bit          ok;
        r = rnd32();
        id = r[3:0];
        exp = expected_resp(addr, len, size, burst);
        exp_data = (exp == OKAY) ? model_mem[addr[3 +: `MEM_AW]] : '0;
        @(posedge clk);
        ar_id <= id;
        ar_addr <= addr;
        ar_len <= len;
        ar_size <= size;
        ar_burst <= burst;
        ar_valid <= 1'b1;
        wait_signal(2, "read address ready", ok);
        @(posedge clk);
        ar_valid <= 1'b0;
        wait_signal(3, "read data valid", ok);
        check_read(name, id, exp, exp_data);
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            if (ar_ready)
                report_failure(name, "read address ready while read data was pending");
            check_read(name, id, exp, exp_data);
        end
        @(posedge clk);
        r_ready <= 1'b1;
        @(posedge clk);
        r_ready <= 1'b0;
    endtask

    task automatic good_write(input string name, input addr_t addr, input data_t data,
                              input strb_t strb, input int stall);
        write_txn(name, addr, 8'd0, `AXI_SIZE_WORD, `AXI_BURST_INCR, data, strb, stall);
    endtask

    task automatic good_read(input string name, input addr_t addr, input int stall);
        read_txn(name, addr, 8'd0, `AXI_SIZE_WORD, `AXI_BURST_INCR, stall);
    endtask

    // ******************************************************************
    // Test sequence.
    // ******************************************************************
    initial begin
        widx_t       idx;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
        logic [31:0] r;
        aw_id <= '0;
        aw_addr <= '0;
        aw_len <= '0;
        aw_size <= '0;
        aw_burst <= '0;
        aw_valid <= 1'b0;
        w_data <= '0;
        w_strb <= '0;
        w_last <= 1'b0;
        w_valid <= 1'b0;
        b_ready <= 1'b0;
        ar_id <= '0;
        ar_addr <= '0;
        ar_len <= '0;
        ar_size <= '0;
        ar_burst <= '0;
        ar_valid <= 1'b0;
        r_ready <= 1'b0;
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < 16; i++) begin
            idx = rand_idx();
            good_write("full write", in_addr(idx), rand_data(), 8'hff, 0);
            good_read("full readback", in_addr(idx), 0);
        end
        for (int i = 0; i < 16; i++) begin
            idx = pick_written();
            r = rnd32();
            good_write("partial write", in_addr(idx), rand_data(), r[7:0], 0);
            good_read("partial readback", in_addr(idx), 0);
        end
        for (int i = 0; i < 12; i++) begin
            idx = pick_written();
            bad_attr(len, size, burst);
            write_txn("bad attr write", in_addr(idx), len, size, burst, rand_data(), 8'hff, 0);
            bad_attr(len, size, burst);
            read_txn("bad attr read", in_addr(idx), len, size, burst, 0);
            good_read("after bad attr", in_addr(idx), 0);
        end
        for (int i = 0; i < 12; i++) begin
            idx = pick_written();
            good_write("out of range write", far_addr(idx), rand_data(), 8'hff, 0);
            good_read("out of range read", far_addr(idx), 0);
            good_read("after out of range", in_addr(idx), 0);
        end
        for (int i = 0; i < 12; i++) begin
            idx = pick_written();
            good_write("stalled write", in_addr(idx), rand_data(), 8'hff, 1 + rand_below(10));
            good_read("stalled read", in_addr(idx), 1 + rand_below(10));
        end

        for (int i = 0; i < 200; i++) begin
            idx = pick_written();
            r = rnd32();
            bad_attr(len, size, burst);
            case (rand_below(6))
                0: good_write("random full write", in_addr(rand_idx()), rand_data(), 8'hff,
                              rand_below(4));
                1: good_write("random partial write", in_addr(idx), rand_data(), r[7:0],
                              rand_below(4));
                2: read_txn("random bad read", in_addr(idx), len, size, burst, rand_below(4));
                3: write_txn("random bad write", in_addr(idx), len, size, burst, rand_data(),
                             r[15:8], rand_below(4));
                4: if (r[16])
                       good_write("random far write", far_addr(idx), rand_data(), 8'hff, 0);
                   else
                       good_read("random far read", far_addr(idx), rand_below(4));
                default: good_read("random read", in_addr(idx), rand_below(4));
            endcase
        end

        $display("Done: %0d value errors, %0d protocol errors, %0d timeouts",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+logic
logic/axi_mem_pkg.sv
logic/word_mem.sv
logic/axi_write_slave.sv
logic/axi_read_slave.sv
logic/axi_mem_top.sv
bench/axi_mem_asserts.sv
bench/axi_mem_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module axi_mem_tb -o axi_mem_sim
./obj_dir/axi_mem_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass"
    exit 1
fi
